/* logic/tcp_pkg.sv */
package tcp_pkg;

    // Flow count and field widths.
    localparam int NUM_FLOWS = 4;
    localparam int FLOWID_W  = 2;
    localparam int SEQ_W     = 32;
    localparam int LEN_W     = 16;

    // Largest data payload of one segment, in bytes.
    localparam int MAX_SEG   = 64;

    typedef logic [FLOWID_W-1:0]  flowid_t;
    typedef logic [SEQ_W-1:0]     seq_t;
    typedef logic [LEN_W-1:0]     len_t;
    typedef logic [NUM_FLOWS-1:0] flow_mask_t;

    typedef struct packed {
        logic ack;
        logic data;
    } tcp_flags_t;

    // Parsed header as it arrives from the receive side.
    typedef struct packed {
        flowid_t flowid;
        seq_t    seq;
        len_t    len;
    } rx_hdr_t;

    typedef struct packed {
        seq_t       seq;
        seq_t       ack;
        tcp_flags_t flags;
    } tcp_hdr_t;

    // One packet on the shared output port.
    typedef struct packed {
        flowid_t  flowid;
        tcp_hdr_t hdr;
        len_t     len;
    } send_pkt_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_e;

endpackage

/* logic/tcp_rx.sv */
`timescale 1ns/1ps

module tcp_rx (
     input                          clk
    ,input                          rst

    ,input                          rx_hdr_val
    ,input  tcp_pkg::rx_hdr_t       rx_hdr
    ,output logic                   rx_hdr_rdy

    ,output tcp_pkg::flowid_t       rx_flowid
    ,input  tcp_pkg::seq_t          rx_exp_seq
    ,input  tcp_pkg::seq_t          rx_head_seq

    ,output logic                   exp_wr_val
    ,output tcp_pkg::flowid_t       exp_wr_flowid
    ,output tcp_pkg::seq_t          exp_wr_seq

    ,output logic                   ack_val
    ,output tcp_pkg::send_pkt_t     ack_pkt
    ,input                          ack_rdy
);

    logic           hdr_xfer;
    logic           in_order;
    tcp_pkg::seq_t  next_exp;

    // A new header fits when the ACK stage is empty or drains this cycle.
    assign rx_hdr_rdy = ~ack_val | ack_rdy;
    assign hdr_xfer   = rx_hdr_val & rx_hdr_rdy;

    assign rx_flowid = rx_hdr.flowid;
    assign in_order  = rx_hdr.seq == rx_exp_seq;
    assign next_exp  = in_order ? rx_exp_seq + tcp_pkg::seq_t'(rx_hdr.len) : rx_exp_seq;

    assign exp_wr_val    = hdr_xfer & in_order;
    assign exp_wr_flowid = rx_hdr.flowid;
    assign exp_wr_seq    = next_exp;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_val <= 1'b0;
        end else if (hdr_xfer) begin
            ack_val <= 1'b1;
        end else if (ack_rdy) begin
            ack_val <= 1'b0;
        end
    end

    // Out-of-order headers still get an ACK, carrying the old expected value.
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            ack_pkt.flowid         <= rx_hdr.flowid;
            ack_pkt.hdr.seq        <= rx_head_seq;
            ack_pkt.hdr.ack        <= next_exp;
            ack_pkt.hdr.flags.ack  <= 1'b1;
            ack_pkt.hdr.flags.data <= 1'b0;
            ack_pkt.len            <= '0;
        end
    end

    ack_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        ack_val && !ack_rdy |=> ack_val && $stable(ack_pkt)
    ) else $error("tcp_rx: staged ACK changed while stalled");

endmodule

/* logic/tcp_tx.sv */
`timescale 1ns/1ps

module tcp_tx (
     input                          clk
    ,input                          rst

    ,input                          grant_val
    ,input  tcp_pkg::flowid_t       grant_flowid
    ,output logic                   grant_rdy

    ,output tcp_pkg::flowid_t       tx_flowid
    ,input  tcp_pkg::seq_t          tx_head_seq
    ,input  tcp_pkg::seq_t          tx_tail_seq
    ,input  tcp_pkg::seq_t          tx_exp_seq

    ,output logic                   head_adv_val
    ,output tcp_pkg::flowid_t       head_adv_flowid
    ,output tcp_pkg::len_t          head_adv_len

    ,output logic                   data_val
    ,output tcp_pkg::send_pkt_t     data_pkt
    ,input                          data_rdy
);

    tcp_pkg::tx_state_e state_q;
    tcp_pkg::tx_state_e state_d;
    logic               grant_xfer;
    tcp_pkg::seq_t      avail;
    tcp_pkg::len_t      seg_len;

    assign grant_rdy  = state_q == tcp_pkg::TX_IDLE;
    assign grant_xfer = grant_val & grant_rdy;
    assign data_val   = state_q == tcp_pkg::TX_SEND;

    assign tx_flowid = grant_flowid;

    // Bytes queued by the application but not yet sent.
    assign avail   = tx_tail_seq - tx_head_seq;
    assign seg_len = (avail > tcp_pkg::seq_t'(tcp_pkg::MAX_SEG))
                   ? tcp_pkg::len_t'(tcp_pkg::MAX_SEG)
                   : tcp_pkg::len_t'(avail);

    // Head moves on the same edge that loads the segment.
    assign head_adv_val    = grant_xfer;
    assign head_adv_flowid = grant_flowid;
    assign head_adv_len    = seg_len;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            tcp_pkg::TX_IDLE: begin
                if (grant_xfer) begin
                    state_d = tcp_pkg::TX_SEND;
                end
            end
            tcp_pkg::TX_SEND: begin
                if (data_rdy) begin
                    state_d = tcp_pkg::TX_IDLE;
                end
            end
            default: begin
                state_d = tcp_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= tcp_pkg::TX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_xfer) begin
            data_pkt.flowid         <= grant_flowid;
            data_pkt.hdr.seq        <= tx_head_seq;
            data_pkt.hdr.ack        <= tx_exp_seq;
            data_pkt.hdr.flags.ack  <= 1'b1;
            data_pkt.hdr.flags.data <= 1'b1;
            data_pkt.len            <= seg_len;
        end
    end

    // A grant for an empty flow would show up here as a zero length.
    seg_len_a: assert property (
        @(posedge clk) disable iff (rst)
        data_val |-> data_pkt.len != '0
                  && data_pkt.len <= tcp_pkg::len_t'(tcp_pkg::MAX_SEG)
    ) else $error("tcp_tx: segment length %0d out of range", data_pkt.len);

endmodule

/* logic/flow_state_regs.sv */
`timescale 1ns/1ps

module flow_state_regs (
     input                          clk
    ,input                          rst

    ,input                          tail_wr_val
    ,input  tcp_pkg::flowid_t       tail_wr_flowid
    ,input  tcp_pkg::seq_t          tail_wr_ptr

    ,input                          exp_wr_val
    ,input  tcp_pkg::flowid_t       exp_wr_flowid
    ,input  tcp_pkg::seq_t          exp_wr_seq

    ,input                          head_adv_val
    ,input  tcp_pkg::flowid_t       head_adv_flowid
    ,input  tcp_pkg::len_t          head_adv_len

    ,input  tcp_pkg::flowid_t       rx_flowid
    ,input  tcp_pkg::flowid_t       tx_flowid

    ,output tcp_pkg::seq_t          rx_exp_seq
    ,output tcp_pkg::seq_t          rx_head_seq
    ,output tcp_pkg::seq_t          tx_head_seq
    ,output tcp_pkg::seq_t          tx_tail_seq
    ,output tcp_pkg::seq_t          tx_exp_seq

    ,output tcp_pkg::flow_mask_t    pending
);

    tcp_pkg::seq_t exp_q  [tcp_pkg::NUM_FLOWS];
    tcp_pkg::seq_t head_q [tcp_pkg::NUM_FLOWS];
    tcp_pkg::seq_t tail_q [tcp_pkg::NUM_FLOWS];

    // All flows start empty with sequence zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tcp_pkg::NUM_FLOWS; i++) begin
                exp_q[i]  <= '0;
                head_q[i] <= '0;
                tail_q[i] <= '0;
            end
        end else begin
            if (exp_wr_val) begin
                exp_q[exp_wr_flowid] <= exp_wr_seq;
            end
            if (head_adv_val) begin
                head_q[head_adv_flowid] <= head_q[head_adv_flowid]
                                         + tcp_pkg::seq_t'(head_adv_len);
            end
            if (tail_wr_val) begin
                tail_q[tail_wr_flowid] <= tail_wr_ptr;
            end
        end
    end

    assign rx_exp_seq  = exp_q[rx_flowid];
    assign rx_head_seq = head_q[rx_flowid];
    assign tx_head_seq = head_q[tx_flowid];
    assign tx_tail_seq = tail_q[tx_flowid];
    assign tx_exp_seq  = exp_q[tx_flowid];

    always_comb begin
        for (int i = 0; i < tcp_pkg::NUM_FLOWS; i++) begin
            pending[i] = head_q[i] != tail_q[i];
        end
    end

    // Distance is taken modulo 2^32 so the check holds across wrap.
    tail_order_a: assert property (
        @(posedge clk) disable iff (rst)
        tail_wr_val |-> $signed(tail_wr_ptr - head_q[tail_wr_flowid]) >= 0
    ) else $error("flow_state_regs: tail of flow %0d written behind head",
                  tail_wr_flowid);

endmodule

/* logic/rr_sched.sv */
`timescale 1ns/1ps

module rr_sched (
     input                          clk
    ,input                          rst

    ,input  tcp_pkg::flow_mask_t    pending

    ,output logic                   grant_val
    ,output tcp_pkg::flowid_t       grant_flowid
    ,input                          grant_rdy
);

    tcp_pkg::flowid_t last_q;
    tcp_pkg::flowid_t cand;
    tcp_pkg::flowid_t pick_flowid;
    logic             pick_val;

    // Search starts just past the last granted flow and wraps around.
    always_comb begin
        pick_val    = 1'b0;
        pick_flowid = last_q;
        cand        = last_q;
        for (int i = 1; i <= tcp_pkg::NUM_FLOWS; i++) begin
            cand = last_q + tcp_pkg::flowid_t'(i);
            if (!pick_val && pending[cand]) begin
                pick_val    = 1'b1;
                pick_flowid = cand;
            end
        end
    end

    // The grant drops for one cycle after a transfer so the head update lands first.
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_val    <= 1'b0;
            grant_flowid <= '0;
            last_q       <= '1;
        end else if (grant_val && grant_rdy) begin
            grant_val <= 1'b0;
            last_q    <= grant_flowid;
        end else if (!grant_val) begin
            grant_val    <= pick_val;
            grant_flowid <= pick_flowid;
        end
    end

endmodule

/* logic/send_pkt_mux.sv */
`timescale 1ns/1ps

module send_pkt_mux (
     input                          clk
    ,input                          rst

    ,input                          ack_val
    ,input  tcp_pkg::send_pkt_t     ack_pkt
    ,output logic                   ack_rdy

    ,input                          data_val
    ,input  tcp_pkg::send_pkt_t     data_pkt
    ,output logic                   data_rdy

    ,output logic                   tx_pkt_val
    ,output tcp_pkg::send_pkt_t     tx_pkt
    ,input                          tx_pkt_rdy
);

    logic out_free;

    assign out_free = ~tx_pkt_val | tx_pkt_rdy;

    // ACKs win, data waits behind them.
    assign ack_rdy  = out_free;
    assign data_rdy = out_free & ~ack_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_pkt_val <= 1'b0;
        end else if (out_free) begin
            tx_pkt_val <= ack_val | data_val;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (ack_val) begin
                tx_pkt <= ack_pkt;
            end else if (data_val) begin
                tx_pkt <= data_pkt;
            end
        end
    end

    one_grant_a: assert property (
        @(posedge clk) disable iff (rst)
        ack_val && data_val |-> !(ack_rdy && data_rdy)
    ) else $error("send_pkt_mux: both inputs accepted in one cycle");

endmodule

/* logic/tcp_engine.sv */
`timescale 1ns/1ps

module tcp_engine (
     input                          clk
    ,input                          rst

    ,input                          rx_hdr_val
    ,input  tcp_pkg::rx_hdr_t       rx_hdr
    ,output logic                   rx_hdr_rdy

    ,input                          tail_wr_val
    ,input  tcp_pkg::flowid_t       tail_wr_flowid
    ,input  tcp_pkg::seq_t          tail_wr_ptr

    ,output logic                   tx_pkt_val
    ,output tcp_pkg::send_pkt_t     tx_pkt
    ,input                          tx_pkt_rdy
);

    tcp_pkg::flowid_t       rx_flowid;
    tcp_pkg::seq_t          rx_exp_seq;
    tcp_pkg::seq_t          rx_head_seq;

    logic                   exp_wr_val;
    tcp_pkg::flowid_t       exp_wr_flowid;
    tcp_pkg::seq_t          exp_wr_seq;

    tcp_pkg::flowid_t       tx_flowid;
    tcp_pkg::seq_t          tx_head_seq;
    tcp_pkg::seq_t          tx_tail_seq;
    tcp_pkg::seq_t          tx_exp_seq;

    logic                   head_adv_val;
    tcp_pkg::flowid_t       head_adv_flowid;
    tcp_pkg::len_t          head_adv_len;

    tcp_pkg::flow_mask_t    pending;
    logic                   grant_val;
    tcp_pkg::flowid_t       grant_flowid;
    logic                   grant_rdy;

    logic                   ack_val;
    tcp_pkg::send_pkt_t     ack_pkt;
    logic                   ack_rdy;
    logic                   data_val;
    tcp_pkg::send_pkt_t     data_pkt;
    logic                   data_rdy;

    tcp_rx rx_engine (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.rx_hdr_val    (rx_hdr_val     )
        ,.rx_hdr        (rx_hdr         )
        ,.rx_hdr_rdy    (rx_hdr_rdy     )
        ,.rx_flowid     (rx_flowid      )
        ,.rx_exp_seq    (rx_exp_seq     )
        ,.rx_head_seq   (rx_head_seq    )
        ,.exp_wr_val    (exp_wr_val     )
        ,.exp_wr_flowid (exp_wr_flowid  )
        ,.exp_wr_seq    (exp_wr_seq     )
        ,.ack_val       (ack_val        )
        ,.ack_pkt       (ack_pkt        )
        ,.ack_rdy       (ack_rdy        )
    );

    tcp_tx tx_engine (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.grant_val         (grant_val          )
        ,.grant_flowid      (grant_flowid       )
        ,.grant_rdy         (grant_rdy          )
        ,.tx_flowid         (tx_flowid          )
        ,.tx_head_seq       (tx_head_seq        )
        ,.tx_tail_seq       (tx_tail_seq        )
        ,.tx_exp_seq        (tx_exp_seq         )
        ,.head_adv_val      (head_adv_val       )
        ,.head_adv_flowid   (head_adv_flowid    )
        ,.head_adv_len      (head_adv_len       )
        ,.data_val          (data_val           )
        ,.data_pkt          (data_pkt           )
        ,.data_rdy          (data_rdy           )
    );

    flow_state_regs flow_regs (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.tail_wr_val       (tail_wr_val        )
        ,.tail_wr_flowid    (tail_wr_flowid     )
        ,.tail_wr_ptr       (tail_wr_ptr        )
        ,.exp_wr_val        (exp_wr_val         )
        ,.exp_wr_flowid     (exp_wr_flowid      )
        ,.exp_wr_seq        (exp_wr_seq         )
        ,.head_adv_val      (head_adv_val       )
        ,.head_adv_flowid   (head_adv_flowid    )
        ,.head_adv_len      (head_adv_len       )
        ,.rx_flowid         (rx_flowid          )
        ,.tx_flowid         (tx_flowid          )
        ,.rx_exp_seq        (rx_exp_seq         )
        ,.rx_head_seq       (rx_head_seq        )
        ,.tx_head_seq       (tx_head_seq        )
        ,.tx_tail_seq       (tx_tail_seq        )
        ,.tx_exp_seq        (tx_exp_seq         )
        ,.pending           (pending            )
    );

    rr_sched tx_scheduler (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.pending       (pending        )
        ,.grant_val     (grant_val      )
        ,.grant_flowid  (grant_flowid   )
        ,.grant_rdy     (grant_rdy      )
    );

    send_pkt_mux tx_mux (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.ack_val       (ack_val        )
        ,.ack_pkt       (ack_pkt        )
        ,.ack_rdy       (ack_rdy        )
        ,.data_val      (data_val       )
        ,.data_pkt      (data_pkt       )
        ,.data_rdy      (data_rdy       )
        ,.tx_pkt_val    (tx_pkt_val     )
        ,.tx_pkt        (tx_pkt         )
        ,.tx_pkt_rdy    (tx_pkt_rdy     )
    );

endmodule

/* dv/tcp_checker.sv */
`timescale 1ns/1ps

module tcp_checker (
     input                          clk
    ,input                          rst

    ,input                          rx_hdr_val
    ,input  tcp_pkg::rx_hdr_t       rx_hdr
    ,input                          rx_hdr_rdy

    ,input                          tail_wr_val
    ,input  tcp_pkg::flowid_t       tail_wr_flowid
    ,input  tcp_pkg::seq_t          tail_wr_ptr

    ,input                          tx_pkt_val
    ,input  tcp_pkg::send_pkt_t     tx_pkt
    ,input                          tx_pkt_rdy

    ,input  logic [2:0]             test_id
    ,input                          test_done
    ,output logic                   model_idle
    ,output int                     err_count
);

    // Model of the flow state, built from port traffic.
    tcp_pkg::seq_t      exp_m  [tcp_pkg::NUM_FLOWS];
    tcp_pkg::seq_t      sent_m [tcp_pkg::NUM_FLOWS];
    tcp_pkg::seq_t      tail_m [tcp_pkg::NUM_FLOWS];

    tcp_pkg::send_pkt_t ack_fifo [8];
    logic [2:0]         ack_wr;
    logic [2:0]         ack_rd;
    int                 acks_owed;

    logic               hdr_in;
    logic               ack_out;
    logic               data_out;
    logic               all_sent;
    logic               have_prev;
    tcp_pkg::flowid_t   prev_flow;
    tcp_pkg::flowid_t   rr_flow;
    tcp_pkg::flowid_t   out_flow;
    tcp_pkg::seq_t      new_exp;
    tcp_pkg::seq_t      avail;
    tcp_pkg::len_t      exp_len;
    tcp_pkg::seq_t      exp_seq_o;
    tcp_pkg::seq_t      exp_ack_o;
    tcp_pkg::send_pkt_t new_ack;
    tcp_pkg::send_pkt_t ack_head;
    int                 err_at_start;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "in_order_rx";
            3'd2:    return "out_of_order_rx";
            3'd3:    return "tx_segmentation";
            3'd4:    return "round_robin";
            3'd5:    return "back_pressure";
            default: return "unknown";
        endcase
    endfunction

    task automatic plain_error(input string msg);
        $display("error in %s: %s", test_name(test_id), msg);
        err_count = err_count + 1;
    endtask

    task automatic value_error(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        $display("mismatch %s %s: expected %0h, actual %0h",
                 test_name(test_id), what, expected, actual);
        err_count = err_count + 1;
    endtask

    initial begin
        err_count    = 0;
        err_at_start = 0;
    end

    assign hdr_in   = rx_hdr_val && rx_hdr_rdy;
    assign ack_out  = tx_pkt_val && tx_pkt_rdy && !tx_pkt.hdr.flags.data;
    assign data_out = tx_pkt_val && tx_pkt_rdy && tx_pkt.hdr.flags.data;
    assign out_flow = tx_pkt.flowid;

    // Only an in-order header moves the expected value.
    assign new_exp = (rx_hdr.seq == exp_m[rx_hdr.flowid])
                   ? exp_m[rx_hdr.flowid] + tcp_pkg::seq_t'(rx_hdr.len)
                   : exp_m[rx_hdr.flowid];

    assign avail     = tail_m[out_flow] - sent_m[out_flow];
    assign exp_len   = (avail < tcp_pkg::seq_t'(tcp_pkg::MAX_SEG))
                     ? tcp_pkg::len_t'(avail)
                     : tcp_pkg::len_t'(tcp_pkg::MAX_SEG);
    assign exp_seq_o = sent_m[out_flow];
    assign exp_ack_o = exp_m[out_flow];
    assign ack_head  = ack_fifo[ack_rd];

    always_comb begin
        new_ack            = '0;
        new_ack.flowid     = rx_hdr.flowid;
        new_ack.hdr.seq    = sent_m[rx_hdr.flowid];
        new_ack.hdr.ack    = new_exp;
        new_ack.hdr.flags  = '{ack: 1'b1, data: 1'b0};
    end

    // Scan backwards so the nearest pending flow after prev_flow wins.
    always_comb begin
        tcp_pkg::flowid_t f;
        rr_flow = prev_flow;
        for (int i = tcp_pkg::NUM_FLOWS; i >= 1; i--) begin
            f = prev_flow + tcp_pkg::flowid_t'(i);
            if (tail_m[f] != sent_m[f]) begin
                rr_flow = f;
            end
        end
    end

    always_comb begin
        all_sent = 1'b1;
        for (int i = 0; i < tcp_pkg::NUM_FLOWS; i++) begin
            if (tail_m[i] != sent_m[i]) begin
                all_sent = 1'b0;
            end
        end
    end

    assign model_idle = (acks_owed == 0) && all_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tcp_pkg::NUM_FLOWS; i++) begin
                exp_m[i]  <= '0;
                sent_m[i] <= '0;
                tail_m[i] <= '0;
            end
            ack_wr    <= '0;
            ack_rd    <= '0;
            acks_owed <= 0;
            have_prev <= 1'b0;
            prev_flow <= '0;
        end else begin
            if (hdr_in) begin
                exp_m[rx_hdr.flowid] <= new_exp;
                ack_wr               <= ack_wr + 3'd1;
            end
            if (ack_out) begin
                ack_rd <= ack_rd + 3'd1;
            end
            acks_owed <= acks_owed + int'(hdr_in) - int'(ack_out);
            if (tail_wr_val) begin
                tail_m[tail_wr_flowid] <= tail_wr_ptr;
            end
            if (data_out) begin
                sent_m[out_flow] <= sent_m[out_flow] + tcp_pkg::seq_t'(exp_len);
                prev_flow        <= out_flow;
                have_prev        <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_in) begin
            ack_fifo[ack_wr] <= new_ack;
        end
    end

    always @(posedge clk) begin
        if (test_done) begin
            $display("test %-16s %s, %0d errors", test_name(test_id),
                     (err_count == err_at_start) ? "ok" : "FAILED",
                     err_count - err_at_start);
            err_at_start = err_count;
        end
    end

    reset_state_a: assert property (
        @(posedge clk) $fell(rst) |-> !tx_pkt_val && rx_hdr_rdy
    ) else plain_error("output valid or header port not ready after reset");

    ack_owed_a: assert property (
        @(posedge clk) disable iff (rst)
        ack_out |-> acks_owed > 0
    ) else plain_error("ACK sent with no received header behind it");

    ack_match_a: assert property (
        @(posedge clk) disable iff (rst)
        ack_out && acks_owed > 0 |-> tx_pkt == ack_head
    ) else value_error("ack packet", $sampled(ack_head), $sampled(tx_pkt));

    data_pending_a: assert property (
        @(posedge clk) disable iff (rst)
        data_out |-> avail != '0
    ) else plain_error("data segment sent for a flow with no queued bytes");

    data_seq_a: assert property (
        @(posedge clk) disable iff (rst)
        data_out |-> tx_pkt.hdr.seq == exp_seq_o
    ) else value_error("data seq", $sampled(exp_seq_o), $sampled(tx_pkt.hdr.seq));

    data_len_a: assert property (
        @(posedge clk) disable iff (rst)
        data_out |-> tx_pkt.len == exp_len
    ) else value_error("data len", $sampled(exp_len), $sampled(tx_pkt.len));

    data_ack_a: assert property (
        @(posedge clk) disable iff (rst)
        data_out |-> tx_pkt.hdr.ack == exp_ack_o && tx_pkt.hdr.flags.ack
    ) else value_error("data ack", $sampled(exp_ack_o), $sampled(tx_pkt.hdr.ack));

    rr_order_a: assert property (
        @(posedge clk) disable iff (rst)
        data_out && have_prev |-> out_flow == rr_flow
    ) else value_error("data flow", $sampled(rr_flow), $sampled(out_flow));

    stall_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        tx_pkt_val && !tx_pkt_rdy |=> tx_pkt_val && $stable(tx_pkt)
    ) else plain_error("output packet changed or dropped while stalled");

endmodule

/* dv/tb_tcp_engine.sv */
`timescale 1ns/1ps

module tb_tcp_engine;

    localparam int CLK_PERIOD = 100;
    localparam int QUARTER    = CLK_PERIOD / 4;

    // Headers plus the most data segments the tests can produce.
    localparam int NUM_ITEMS  = 8 + 12 + 16 + 5 + 16 + 19;

    logic                   clk;
    logic                   rst;
    logic                   rx_hdr_val;
    tcp_pkg::rx_hdr_t       rx_hdr;
    logic                   rx_hdr_rdy;
    logic                   tail_wr_val;
    tcp_pkg::flowid_t       tail_wr_flowid;
    tcp_pkg::seq_t          tail_wr_ptr;
    logic                   tx_pkt_val;
    tcp_pkg::send_pkt_t     tx_pkt;
    logic                   tx_pkt_rdy;

    logic [2:0]             test_id;
    logic                   test_done;
    logic                   model_idle;
    int                     err_count;
    int                     tests_run;
    logic                   bp_done;

    // Stimulus-side bookkeeping used to pick sequence numbers and tails.
    tcp_pkg::seq_t          next_seq [tcp_pkg::NUM_FLOWS];
    tcp_pkg::seq_t          tail_ptr [tcp_pkg::NUM_FLOWS];

    tcp_engine uut (
         .clk               (clk            )
        ,.rst               (rst            )
        ,.rx_hdr_val        (rx_hdr_val     )
        ,.rx_hdr            (rx_hdr         )
        ,.rx_hdr_rdy        (rx_hdr_rdy     )
        ,.tail_wr_val       (tail_wr_val    )
        ,.tail_wr_flowid    (tail_wr_flowid )
        ,.tail_wr_ptr       (tail_wr_ptr    )
        ,.tx_pkt_val        (tx_pkt_val     )
        ,.tx_pkt            (tx_pkt         )
        ,.tx_pkt_rdy        (tx_pkt_rdy     )
    );

    tcp_checker chk (
         .clk               (clk            )
        ,.rst               (rst            )
        ,.rx_hdr_val        (rx_hdr_val     )
        ,.rx_hdr            (rx_hdr         )
        ,.rx_hdr_rdy        (rx_hdr_rdy     )
        ,.tail_wr_val       (tail_wr_val    )
        ,.tail_wr_flowid    (tail_wr_flowid )
        ,.tail_wr_ptr       (tail_wr_ptr    )
        ,.tx_pkt_val        (tx_pkt_val     )
        ,.tx_pkt            (tx_pkt         )
        ,.tx_pkt_rdy        (tx_pkt_rdy     )
        ,.test_id           (test_id        )
        ,.test_done         (test_done      )
        ,.model_idle        (model_idle     )
        ,.err_count         (err_count      )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_ITEMS * 40 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_ITEMS * 40);
        $display("Errors found");
        $finish;
    end

    // Ready is looked at mid low phase, after the falling-edge drive settles.
    task automatic send_hdr(input tcp_pkg::flowid_t f, input tcp_pkg::seq_t s,
                            input tcp_pkg::len_t l);
        @(negedge clk);
        rx_hdr_val = 1'b1;
        rx_hdr     = '{flowid: f, seq: s, len: l};
        #(QUARTER);
        while (!rx_hdr_rdy) begin
            @(negedge clk);
            #(QUARTER);
        end
        @(negedge clk);
        rx_hdr_val = 1'b0;
    endtask

    task automatic send_in_order(input tcp_pkg::flowid_t f);
        tcp_pkg::len_t l;
        l = tcp_pkg::len_t'(1 + $urandom % 1460);
        send_hdr(f, next_seq[f], l);
        next_seq[f] = next_seq[f] + tcp_pkg::seq_t'(l);
    endtask

    task automatic send_out_of_order(input tcp_pkg::flowid_t f);
        send_hdr(f, next_seq[f] + 1 + $urandom % 1000,
                 tcp_pkg::len_t'(1 + $urandom % 1460));
    endtask

    // Back-to-back tail writes to count flows, in circular order from first.
    task automatic write_tails(input tcp_pkg::flowid_t first, input int count,
                               input int min_step, input int max_step);
        tcp_pkg::flowid_t f;
        f = first;
        repeat (count) begin
            @(negedge clk);
            tail_ptr[f]    = tail_ptr[f] + min_step + $urandom % (max_step - min_step + 1);
            tail_wr_val    = 1'b1;
            tail_wr_flowid = f;
            tail_wr_ptr    = tail_ptr[f];
            f              = f + 1'b1;
        end
        @(negedge clk);
        tail_wr_val = 1'b0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        while (!model_idle) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        test_id   = test_id + 3'd1;
        tests_run = tests_run + 1;
    endtask

    initial begin
        void'($urandom(32'hc845_5cbb));
        clk            = 1'b0;
        rst            = 1'b1;
        rx_hdr_val     = 1'b0;
        rx_hdr         = '0;
        tail_wr_val    = 1'b0;
        tail_wr_flowid = '0;
        tail_wr_ptr    = '0;
        tx_pkt_rdy     = 1'b1;
        test_id        = '0;
        test_done      = 1'b0;
        tests_run      = 0;
        bp_done        = 1'b0;
        for (int i = 0; i < tcp_pkg::NUM_FLOWS; i++) begin
            next_seq[i] = '0;
            tail_ptr[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        finish_test();

        repeat (8) send_in_order(tcp_pkg::flowid_t'($urandom % 4));
        finish_test();

        repeat (6) begin
            tcp_pkg::flowid_t f;
            f = tcp_pkg::flowid_t'($urandom % 4);
            send_out_of_order(f);
            send_in_order(f);
        end
        finish_test();

        write_tails(2'd2, 1, 100, 300);
        finish_test();

        // Flow 2 was served last, so the writes start at flow 3.
        write_tails(2'd3, 4, 1, 200);
        finish_test();

        // Receive on flows 0 and 1 while flow 3 transmits under stalls.
        fork
            begin
                while (!bp_done) begin
                    @(negedge clk);
                    tx_pkt_rdy = ($urandom % 3) != 0;
                end
                tx_pkt_rdy = 1'b1;
            end
            begin
                fork
                    repeat (8) begin
                        tcp_pkg::flowid_t f;
                        f = tcp_pkg::flowid_t'($urandom % 2);
                        send_out_of_order(f);
                        send_in_order(f);
                    end
                    write_tails(2'd3, 1, 400, 1200);
                join
                bp_done = 1'b1;
            end
        join
        finish_test();

        $display("tests run: %0d, errors: %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* all.f */
logic/tcp_pkg.sv
logic/tcp_rx.sv
logic/tcp_tx.sv
logic/flow_state_regs.sv
logic/rr_sched.sv
logic/send_pkt_mux.sv
logic/tcp_engine.sv
dv/tcp_checker.sv
dv/tb_tcp_engine.sv

/* Makefile */
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f all.f --top-module tb_tcp_engine -Mdir obj_dir
	./obj_dir/Vtb_tcp_engine | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
